/* design/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // bus widths.
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // pslverr encodings.
    localparam logic resp_okay   = 1'b0;
    localparam logic resp_slverr = 1'b1;

endpackage

`default_nettype wire

/* design/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

    localparam int gpio_width = 16;
    localparam int gpio_bytes = gpio_width / 8;

    // register offsets, decoded on the low address byte.
    localparam int offset_width = 8;

    localparam logic [offset_width-1:0] reg_idr    = 8'h00;
    localparam logic [offset_width-1:0] reg_odr    = 8'h04;
    localparam logic [offset_width-1:0] reg_moder  = 8'h08;
    localparam logic [offset_width-1:0] reg_otyper = 8'h0C;
    localparam logic [offset_width-1:0] reg_fsr0   = 8'h10;
    localparam logic [offset_width-1:0] reg_fsr1   = 8'h14;
    localparam logic [offset_width-1:0] reg_ier    = 8'h18;

    // two select bits per pin.
    localparam int func_width = 2;

    // code 0 keeps the pin on plain gpio, 1 to 3 pick the alternate source.
    localparam logic [func_width-1:0] func_gpio = 2'd0;

endpackage

`default_nettype wire

/* design/apb_arbiter.sv */
`default_nettype none

module apb_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           host_psel,
    input  logic                           host_penable,
    input  logic                           host_pwrite,
    input  logic [apb_pkg::addr_width-1:0] host_paddr,
    input  logic [apb_pkg::data_width-1:0] host_pwdata,
    input  logic [apb_pkg::strb_width-1:0] host_pstrb,
    output logic [apb_pkg::data_width-1:0] host_prdata,
    output logic                           host_pready,
    output logic                           host_pslverr,

    input  logic                           aux_psel,
    input  logic                           aux_penable,
    input  logic                           aux_pwrite,
    input  logic [apb_pkg::addr_width-1:0] aux_paddr,
    input  logic [apb_pkg::data_width-1:0] aux_pwdata,
    input  logic [apb_pkg::strb_width-1:0] aux_pstrb,
    output logic [apb_pkg::data_width-1:0] aux_prdata,
    output logic                           aux_pready,
    output logic                           aux_pslverr,

    output logic                           bus_psel,
    output logic                           bus_penable,
    output logic                           bus_pwrite,
    output logic [apb_pkg::addr_width-1:0] bus_paddr,
    output logic [apb_pkg::data_width-1:0] bus_pwdata,
    output logic [apb_pkg::strb_width-1:0] bus_pstrb,
    input  logic [apb_pkg::data_width-1:0] bus_prdata,
    input  logic                           bus_pready,
    input  logic                           bus_pslverr
);

    // 0 selects the host, 1 the aux master.
    logic sel_aux;
    logic grant_q;
    logic last_q;
    logic active_q;
    logic done;

    // arbitrate only between transfers, otherwise stay with the owner.
    always_comb begin
        if (active_q) begin
            sel_aux = grant_q;
        end else if (host_psel && aux_psel) begin
            sel_aux = !last_q;
        end else if (host_psel) begin
            sel_aux = 1'b0;
        end else if (aux_psel) begin
            sel_aux = 1'b1;
        end else begin
            sel_aux = grant_q;
        end
    end

    assign bus_psel   = sel_aux ? aux_psel   : host_psel;
    assign bus_pwrite = sel_aux ? aux_pwrite : host_pwrite;
    assign bus_paddr  = sel_aux ? aux_paddr  : host_paddr;
    assign bus_pwdata = sel_aux ? aux_pwdata : host_pwdata;
    assign bus_pstrb  = sel_aux ? aux_pstrb  : host_pstrb;

    // the first bus cycle of a grant is always a setup cycle.
    assign bus_penable = active_q && (sel_aux ? aux_penable : host_penable);

    assign done = bus_psel && bus_penable && bus_pready;

    assign host_prdata  = sel_aux ? '0 : bus_prdata;
    assign host_pready  = !sel_aux && bus_pready;
    assign host_pslverr = !sel_aux && bus_pslverr;

    assign aux_prdata  = sel_aux ? bus_prdata : '0;
    assign aux_pready  = sel_aux && bus_pready;
    assign aux_pslverr = sel_aux && bus_pslverr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q  <= 1'b0;
            last_q   <= 1'b0;
            active_q <= 1'b0;
        end else begin
            grant_q  <= sel_aux;
            active_q <= bus_psel && !done;
            if (done) begin
                last_q <= sel_aux;
            end
        end
    end

endmodule

`default_nettype wire

/* design/gpio_regs.sv */
`default_nettype none

module gpio_regs (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [apb_pkg::addr_width-1:0] paddr,
    input  logic [apb_pkg::data_width-1:0] pwdata,
    input  logic [apb_pkg::strb_width-1:0] pstrb,
    output logic [apb_pkg::data_width-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,

    input  logic                           pause_req,
    output logic                           pause_ack,

    input  logic [gpio_pkg::gpio_width-1:0] idr,
    output logic [gpio_pkg::gpio_width-1:0] odr,
    output logic [gpio_pkg::gpio_width-1:0] moder,
    output logic [gpio_pkg::gpio_width-1:0] otyper,
    output logic [gpio_pkg::gpio_width-1:0] fsr0,
    output logic [gpio_pkg::gpio_width-1:0] fsr1,

    output logic                           irq
);

    import apb_pkg::*;
    import gpio_pkg::*;

    logic [offset_width-1:0] offset;
    logic                    access;
    logic                    wr_en;

    logic [gpio_width-1:0] odr_q;
    logic [gpio_width-1:0] moder_q;
    logic [gpio_width-1:0] otyper_q;
    logic [gpio_width-1:0] fsr0_q;
    logic [gpio_width-1:0] fsr1_q;
    logic [gpio_width-1:0] ier_q;
    logic [gpio_width-1:0] rdata;

    logic pause_ack_q;
    logic irq_q;

    assign offset = paddr[offset_width-1:0];
    assign access = psel && penable;

    // access phase completes at once unless paused.
    assign pready  = access && !pause_ack_q;
    assign wr_en   = pready && pwrite;
    assign pslverr = (pready && pwrite && offset == reg_idr) ? resp_slverr : resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            odr_q    <= '0;
            moder_q  <= '0;
            otyper_q <= '0;
            fsr0_q   <= '0;
            fsr1_q   <= '0;
            ier_q    <= '0;
        end else if (wr_en) begin
            for (int b = 0; b < gpio_bytes; b++) begin
                if (pstrb[b]) begin
                    case (offset)
                        reg_odr:    odr_q[b*8 +: 8]    <= pwdata[b*8 +: 8];
                        reg_moder:  moder_q[b*8 +: 8]  <= pwdata[b*8 +: 8];
                        reg_otyper: otyper_q[b*8 +: 8] <= pwdata[b*8 +: 8];
                        reg_fsr0:   fsr0_q[b*8 +: 8]   <= pwdata[b*8 +: 8];
                        reg_fsr1:   fsr1_q[b*8 +: 8]   <= pwdata[b*8 +: 8];
                        reg_ier:    ier_q[b*8 +: 8]    <= pwdata[b*8 +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    // unmapped offsets read as zero.
    always_comb begin
        case (offset)
            reg_idr:    rdata = idr;
            reg_odr:    rdata = odr_q;
            reg_moder:  rdata = moder_q;
            reg_otyper: rdata = otyper_q;
            reg_fsr0:   rdata = fsr0_q;
            reg_fsr1:   rdata = fsr1_q;
            reg_ier:    rdata = ier_q;
            default:    rdata = '0;
        endcase
    end

    assign prdata = {{(data_width - gpio_width){1'b0}}, rdata};

    // ack once no access phase is pending, hold while requested.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause_ack_q <= 1'b0;
        end else begin
            pause_ack_q <= pause_req && (pause_ack_q || !access);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(ier_q & idr);
        end
    end

    assign pause_ack = pause_ack_q;
    assign irq       = irq_q;

    assign odr    = odr_q;
    assign moder  = moder_q;
    assign otyper = otyper_q;
    assign fsr0   = fsr0_q;
    assign fsr1   = fsr1_q;

endmodule

`default_nettype wire

/* design/gpio_pad_ctrl.sv */
`default_nettype none

module gpio_pad_ctrl (
    input  logic                                                 clk,
    input  logic                                                 rst_n,

    input  logic [gpio_pkg::gpio_width-1:0]                      pad_i,
    output logic [gpio_pkg::gpio_width-1:0]                      pad_o,
    output logic [gpio_pkg::gpio_width-1:0]                      pad_oe,

    input  logic [gpio_pkg::gpio_width-1:0]                      alt_o,
    input  logic [gpio_pkg::gpio_width-1:0]                      alt_oe,

    input  logic [gpio_pkg::gpio_width-1:0]                      odr,
    input  logic [gpio_pkg::gpio_width-1:0]                      moder,
    input  logic [gpio_pkg::gpio_width-1:0]                      otyper,
    input  logic [gpio_pkg::gpio_width-1:0]                      fsr0,
    input  logic [gpio_pkg::gpio_width-1:0]                      fsr1,

    output logic [gpio_pkg::gpio_width-1:0]                      idr,
    output logic [gpio_pkg::func_width*gpio_pkg::gpio_width-1:0] func
);

    import gpio_pkg::*;

    logic [gpio_width-1:0] sync_q1;
    logic [gpio_width-1:0] sync_q2;

    // pin i sits at bits 2i and 2i+1.
    assign func = {fsr1, fsr0};

    always_comb begin
        logic [func_width-1:0] code;

        for (int i = 0; i < gpio_width; i++) begin
            code = func[i*func_width +: func_width];
            if (code == func_gpio) begin
                pad_o[i]  = odr[i];
                // open drain only drives the low level.
                pad_oe[i] = moder[i] && !(otyper[i] && odr[i]);
            end else begin
                pad_o[i]  = alt_o[i];
                pad_oe[i] = alt_oe[i];
            end
        end
    end

    // two-flop input synchronizer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= pad_i;
            sync_q2 <= sync_q1;
        end
    end

    assign idr = sync_q2;

endmodule

`default_nettype wire

/* design/gpio_subsys.sv */
`default_nettype none

module gpio_subsys (
    input  logic                                                 clk,
    input  logic                                                 rst_n,

    input  logic                                                 host_psel,
    input  logic                                                 host_penable,
    input  logic                                                 host_pwrite,
    input  logic [apb_pkg::addr_width-1:0]                       host_paddr,
    input  logic [apb_pkg::data_width-1:0]                       host_pwdata,
    input  logic [apb_pkg::strb_width-1:0]                       host_pstrb,
    output logic [apb_pkg::data_width-1:0]                       host_prdata,
    output logic                                                 host_pready,
    output logic                                                 host_pslverr,

    input  logic                                                 aux_psel,
    input  logic                                                 aux_penable,
    input  logic                                                 aux_pwrite,
    input  logic [apb_pkg::addr_width-1:0]                       aux_paddr,
    input  logic [apb_pkg::data_width-1:0]                       aux_pwdata,
    input  logic [apb_pkg::strb_width-1:0]                       aux_pstrb,
    output logic [apb_pkg::data_width-1:0]                       aux_prdata,
    output logic                                                 aux_pready,
    output logic                                                 aux_pslverr,

    input  logic                                                 pause_req,
    output logic                                                 pause_ack,
    output logic                                                 irq,

    input  logic [gpio_pkg::gpio_width-1:0]                      pad_i,
    output logic [gpio_pkg::gpio_width-1:0]                      pad_o,
    output logic [gpio_pkg::gpio_width-1:0]                      pad_oe,
    input  logic [gpio_pkg::gpio_width-1:0]                      alt_o,
    input  logic [gpio_pkg::gpio_width-1:0]                      alt_oe,
    output logic [gpio_pkg::func_width*gpio_pkg::gpio_width-1:0] func
);

    import apb_pkg::*;
    import gpio_pkg::*;

    // shared register bus.
    logic                  bus_psel;
    logic                  bus_penable;
    logic                  bus_pwrite;
    logic [addr_width-1:0] bus_paddr;
    logic [data_width-1:0] bus_pwdata;
    logic [strb_width-1:0] bus_pstrb;
    logic [data_width-1:0] bus_prdata;
    logic                  bus_pready;
    logic                  bus_pslverr;

    logic [gpio_width-1:0] idr;
    logic [gpio_width-1:0] odr;
    logic [gpio_width-1:0] moder;
    logic [gpio_width-1:0] otyper;
    logic [gpio_width-1:0] fsr0;
    logic [gpio_width-1:0] fsr1;

    apb_arbiter apb_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_psel    (host_psel),
        .host_penable (host_penable),
        .host_pwrite  (host_pwrite),
        .host_paddr   (host_paddr),
        .host_pwdata  (host_pwdata),
        .host_pstrb   (host_pstrb),
        .host_prdata  (host_prdata),
        .host_pready  (host_pready),
        .host_pslverr (host_pslverr),
        .aux_psel     (aux_psel),
        .aux_penable  (aux_penable),
        .aux_pwrite   (aux_pwrite),
        .aux_paddr    (aux_paddr),
        .aux_pwdata   (aux_pwdata),
        .aux_pstrb    (aux_pstrb),
        .aux_prdata   (aux_prdata),
        .aux_pready   (aux_pready),
        .aux_pslverr  (aux_pslverr),
        .bus_psel     (bus_psel),
        .bus_penable  (bus_penable),
        .bus_pwrite   (bus_pwrite),
        .bus_paddr    (bus_paddr),
        .bus_pwdata   (bus_pwdata),
        .bus_pstrb    (bus_pstrb),
        .bus_prdata   (bus_prdata),
        .bus_pready   (bus_pready),
        .bus_pslverr  (bus_pslverr)
    );

    gpio_regs gpio_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (bus_psel),
        .penable   (bus_penable),
        .pwrite    (bus_pwrite),
        .paddr     (bus_paddr),
        .pwdata    (bus_pwdata),
        .pstrb     (bus_pstrb),
        .prdata    (bus_prdata),
        .pready    (bus_pready),
        .pslverr   (bus_pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .idr       (idr),
        .odr       (odr),
        .moder     (moder),
        .otyper    (otyper),
        .fsr0      (fsr0),
        .fsr1      (fsr1),
        .irq       (irq)
    );

    gpio_pad_ctrl gpio_pad_ctrl_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .pad_i  (pad_i),
        .pad_o  (pad_o),
        .pad_oe (pad_oe),
        .alt_o  (alt_o),
        .alt_oe (alt_oe),
        .odr    (odr),
        .moder  (moder),
        .otyper (otyper),
        .fsr0   (fsr0),
        .fsr1   (fsr1),
        .idr    (idr),
        .func   (func)
    );

endmodule

`default_nettype wire

/* test/gpio_checker.sv */
`default_nettype none

module gpio_checker (
    input  logic                                                 clk,
    input  logic [gpio_pkg::gpio_width-1:0]                      pad_o,
    input  logic [gpio_pkg::gpio_width-1:0]                      pad_oe,
    input  logic [gpio_pkg::func_width*gpio_pkg::gpio_width-1:0] func,
    input  logic                                                 irq,
    input  logic                                                 pause_ack,
    input  logic                                                 host_pready,
    input  logic                                                 aux_pready
);

    timeunit 1ns;
    timeprecision 100ps;

    import gpio_pkg::*;

    int error_count = 0;
    int test_errors = 0;
    int test_count  = 0;
    int check_count = 0;

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        check_count++;
        if (!cond) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %0d ns: %s", $time, what);
        end
    endtask

    // pad outputs against the values the reference gives.
    task automatic compare_pins(input logic [gpio_width-1:0] exp_pad_o,
                                input logic [gpio_width-1:0] exp_pad_oe,
                                input logic [func_width*gpio_width-1:0] exp_func,
                                input logic exp_irq);
        compare_word("pad_o", 32'(pad_o), 32'(exp_pad_o));
        compare_word("pad_oe", 32'(pad_oe), 32'(exp_pad_oe));
        compare_word("func", func, exp_func);
        compare_word("irq", 32'(irq), 32'(exp_irq));
    endtask

    // nothing may complete while the register block is paused.
    always @(negedge clk) begin
        if (pause_ack && (host_pready || aux_pready)) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %0d ns: transfer completed while paused", $time);
        end
    end

    task automatic end_test(input string name);
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d, %s: ok", test_count, name);
        end else begin
            $display("test %0d, %s: %0d errors", test_count, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    endtask

endmodule

`default_nettype wire

/* test/gpio_subsys_tb.sv */
`default_nettype none

module gpio_subsys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import apb_pkg::*;
    import gpio_pkg::*;

    localparam int clk_period  = 40;
    localparam int drive_delay = 2;
    localparam int wait_limit  = 64;

    logic                  clk;
    logic                  rst_n;

    logic                  host_psel;
    logic                  host_penable;
    logic                  host_pwrite;
    logic [addr_width-1:0] host_paddr;
    logic [data_width-1:0] host_pwdata;
    logic [strb_width-1:0] host_pstrb;
    logic [data_width-1:0] host_prdata;
    logic                  host_pready;
    logic                  host_pslverr;

    logic                  aux_psel;
    logic                  aux_penable;
    logic                  aux_pwrite;
    logic [addr_width-1:0] aux_paddr;
    logic [data_width-1:0] aux_pwdata;
    logic [strb_width-1:0] aux_pstrb;
    logic [data_width-1:0] aux_prdata;
    logic                  aux_pready;
    logic                  aux_pslverr;

    logic                             pause_req;
    logic                             pause_ack;
    logic                             irq;
    logic [gpio_width-1:0]            pad_i;
    logic [gpio_width-1:0]            pad_o;
    logic [gpio_width-1:0]            pad_oe;
    logic [gpio_width-1:0]            alt_o;
    logic [gpio_width-1:0]            alt_oe;
    logic [func_width*gpio_width-1:0] func;

    // shadow copy of the writable registers.
    logic [gpio_width-1:0] sh_odr;
    logic [gpio_width-1:0] sh_moder;
    logic [gpio_width-1:0] sh_otyper;
    logic [gpio_width-1:0] sh_fsr0;
    logic [gpio_width-1:0] sh_fsr1;
    logic [gpio_width-1:0] sh_ier;

    integer seed = 32'h3f94;
    int     order_q[$];
    int     exp_order_q[$];
    event   timed_out;

    gpio_subsys gpio_subsys_inst (.*);

    gpio_checker checker_inst (
        .clk         (clk),
        .pad_o       (pad_o),
        .pad_oe      (pad_oe),
        .func        (func),
        .irq         (irq),
        .pause_ack   (pause_ack),
        .host_pready (host_pready),
        .aux_pready  (aux_pready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = !clk;
    end

    initial begin
        @(timed_out);
        $display("TB FAILED");
        $finish;
    end

    task automatic raise_timeout(input string what);
        $display("timeout: %s did not finish in %0d cycles", what, wait_limit);
        -> timed_out;
    endtask

    function automatic logic [func_width-1:0] ref_code(input int pin);
        if (pin < 8) begin
            return sh_fsr0[2*pin +: 2];
        end
        return sh_fsr1[2*(pin-8) +: 2];
    endfunction

    function automatic logic [data_width-1:0] ref_read(input logic [offset_width-1:0] off);
        case (off)
            reg_idr:    return 32'(pad_i);
            reg_odr:    return 32'(sh_odr);
            reg_moder:  return 32'(sh_moder);
            reg_otyper: return 32'(sh_otyper);
            reg_fsr0:   return 32'(sh_fsr0);
            reg_fsr1:   return 32'(sh_fsr1);
            reg_ier:    return 32'(sh_ier);
            default:    return '0;
        endcase
    endfunction

    function automatic logic ref_resp(input logic wr, input logic [offset_width-1:0] off);
        return (wr && off == reg_idr) ? resp_slverr : resp_okay;
    endfunction

    // want_oe picks the enable instead of the pad value.
    function automatic logic [gpio_width-1:0] ref_pad(input bit want_oe);
        logic [gpio_width-1:0] res;
        for (int i = 0; i < gpio_width; i++) begin
            if (ref_code(i) == func_gpio) begin
                // open drain drives the pin only while odr is 0.
                if (want_oe && sh_otyper[i]) begin
                    res[i] = sh_moder[i] && !sh_odr[i];
                end else begin
                    res[i] = want_oe ? sh_moder[i] : sh_odr[i];
                end
            end else begin
                res[i] = want_oe ? alt_oe[i] : alt_o[i];
            end
        end
        return res;
    endfunction

    function automatic logic [func_width*gpio_width-1:0] ref_func();
        logic [func_width*gpio_width-1:0] res;
        for (int i = 0; i < gpio_width; i++) begin
            res[2*i +: 2] = ref_code(i);
        end
        return res;
    endfunction

    function automatic logic ref_irq();
        return |(sh_ier & pad_i);
    endfunction

    task automatic apply_write(input logic [offset_width-1:0] off,
                               input logic [data_width-1:0] data, input logic [3:0] strb);
        for (int b = 0; b < 2; b++) begin
            if (strb[b]) begin
                case (off)
                    reg_odr:    sh_odr[b*8 +: 8]    = data[b*8 +: 8];
                    reg_moder:  sh_moder[b*8 +: 8]  = data[b*8 +: 8];
                    reg_otyper: sh_otyper[b*8 +: 8] = data[b*8 +: 8];
                    reg_fsr0:   sh_fsr0[b*8 +: 8]   = data[b*8 +: 8];
                    reg_fsr1:   sh_fsr1[b*8 +: 8]   = data[b*8 +: 8];
                    reg_ier:    sh_ier[b*8 +: 8]    = data[b*8 +: 8];
                    default: ;
                endcase
            end
        end
    endtask

    task automatic host_xfer(input logic wr, input logic [offset_width-1:0] off,
                             input logic [data_width-1:0] wdata, input logic [3:0] strb,
                             output logic [data_width-1:0] rdata, output logic resp);
        int  n;
        logic got;
        @(posedge clk);
        #drive_delay;
        host_psel    = 1'b1;
        host_penable = 1'b0;
        host_pwrite  = wr;
        host_paddr   = 32'(off);
        host_pwdata  = wdata;
        host_pstrb   = strb;
        @(posedge clk);
        #drive_delay;
        host_penable = 1'b1;
        got   = 1'b0;
        n     = 0;
        rdata = '0;
        resp  = 1'b0;
        while (!got && n < wait_limit) begin
            @(negedge clk);
            if (host_pready) begin
                rdata = host_prdata;
                resp  = host_pslverr;
                got   = 1'b1;
            end
            @(posedge clk);
            #drive_delay;
            n++;
        end
        host_psel    = 1'b0;
        host_penable = 1'b0;
        if (!got) begin
            raise_timeout("host transfer");
        end
    endtask

    task automatic aux_xfer(input logic wr, input logic [offset_width-1:0] off,
                            input logic [data_width-1:0] wdata, input logic [3:0] strb,
                            output logic [data_width-1:0] rdata, output logic resp);
        int  n;
        logic got;
        @(posedge clk);
        #drive_delay;
        aux_psel    = 1'b1;
        aux_penable = 1'b0;
        aux_pwrite  = wr;
        aux_paddr   = 32'(off);
        aux_pwdata  = wdata;
        aux_pstrb   = strb;
        @(posedge clk);
        #drive_delay;
        aux_penable = 1'b1;
        got   = 1'b0;
        n     = 0;
        rdata = '0;
        resp  = 1'b0;
        while (!got && n < wait_limit) begin
            @(negedge clk);
            if (aux_pready) begin
                rdata = aux_prdata;
                resp  = aux_pslverr;
                got   = 1'b1;
            end
            @(posedge clk);
            #drive_delay;
            n++;
        end
        aux_psel    = 1'b0;
        aux_penable = 1'b0;
        if (!got) begin
            raise_timeout("aux transfer");
        end
    endtask

    // is_aux picks the master port.
    task automatic do_write(input bit is_aux, input logic [offset_width-1:0] off,
                            input logic [data_width-1:0] data, input logic [3:0] strb);
        logic [data_width-1:0] rdata;
        logic                  resp;
        if (is_aux) begin
            aux_xfer(1'b1, off, data, strb, rdata, resp);
        end else begin
            host_xfer(1'b1, off, data, strb, rdata, resp);
        end
        checker_inst.compare_word($sformatf("write resp at %h", off), 32'(resp),
                                  32'(ref_resp(1'b1, off)));
        apply_write(off, data, strb);
        order_q.push_back(is_aux);
    endtask

    task automatic do_read(input bit is_aux, input logic [offset_width-1:0] off);
        logic [data_width-1:0] rdata;
        logic                  resp;
        if (is_aux) begin
            aux_xfer(1'b0, off, '0, '0, rdata, resp);
        end else begin
            host_xfer(1'b0, off, '0, '0, rdata, resp);
        end
        checker_inst.compare_word($sformatf("read data at %h", off), rdata, ref_read(off));
        checker_inst.compare_word($sformatf("read resp at %h", off), 32'(resp), 32'(resp_okay));
    endtask

    task automatic check_pads();
        @(negedge clk);
        checker_inst.compare_pins(ref_pad(1'b0), ref_pad(1'b1), ref_func(), ref_irq());
    endtask

    initial begin
        logic [offset_width-1:0] off;
        logic [data_width-1:0]   data;
        time                     t_rel;
        time                     t_done;
        int                      n;
        bit                      lone_aux;

        rst_n        = 1'b0;
        host_psel    = 1'b0;
        host_penable = 1'b0;
        host_pwrite  = 1'b0;
        host_paddr   = '0;
        host_pwdata  = '0;
        host_pstrb   = '0;
        aux_psel     = 1'b0;
        aux_penable  = 1'b0;
        aux_pwrite   = 1'b0;
        aux_paddr    = '0;
        aux_pwdata   = '0;
        aux_pstrb    = '0;
        pause_req    = 1'b0;
        pad_i        = '0;
        alt_o        = '0;
        alt_oe       = '0;
        sh_odr       = '0;
        sh_moder     = '0;
        sh_otyper    = '0;
        sh_fsr0      = '0;
        sh_fsr1      = '0;
        sh_ier       = '0;
        repeat (2) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        // offsets up to 0x1c, the last one unmapped.
        repeat (40) begin
            off = 8'(($random(seed) & 7) * 4);
            do_write(1'b0, off, $random(seed), 4'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            do_read(1'b0, 8'(i * 4));
        end
        checker_inst.end_test("random register access");

        do_write(1'b0, reg_ier, $random(seed), 4'h3);
        repeat (6) begin
            @(posedge clk);
            #drive_delay;
            pad_i = $random(seed);
            repeat (3) @(posedge clk);
            do_read(1'b0, reg_idr);
            check_pads();
        end
        checker_inst.end_test("input data and irq");

        repeat (20) begin
            @(posedge clk);
            #drive_delay;
            alt_o  = $random(seed);
            alt_oe = $random(seed);
            do_write(1'b0, reg_moder, $random(seed), 4'h3);
            do_write(1'b0, reg_otyper, $random(seed), 4'h3);
            do_write(1'b0, reg_odr, $random(seed), 4'h3);
            do_write(1'b0, reg_fsr0, $random(seed), 4'h3);
            do_write(1'b0, reg_fsr1, $random(seed), 4'h3);
            check_pads();
        end
        checker_inst.end_test("pad output and function select");

        order_q.delete();
        exp_order_q.delete();
        for (int i = 0; i < 6; i++) begin
            // a lone transfer sets which master was granted last.
            lone_aux = (i % 2 == 1);
            do_write(lone_aux, reg_odr, $random(seed), 4'h3);
            fork
                do_write(1'b1, reg_odr, $random(seed), 4'h3);
                do_write(1'b0, reg_odr, $random(seed), 4'h3);
            join
            // the master not granted last wins the tie.
            exp_order_q.push_back(lone_aux);
            exp_order_q.push_back(!lone_aux);
            exp_order_q.push_back(lone_aux);
        end
        checker_inst.compare_word("completed transfers", 32'(order_q.size()),
                                  32'(exp_order_q.size()));
        for (int i = 0; i < order_q.size() && i < exp_order_q.size(); i++) begin
            checker_inst.compare_word($sformatf("master of completion %0d", i),
                                      32'(order_q[i]), 32'(exp_order_q[i]));
        end
        fork
            do_read(1'b0, reg_odr);
            do_read(1'b1, reg_moder);
        join
        checker_inst.end_test("two master arbitration");

        data = $random(seed);
        fork
            begin
                do_write(1'b0, reg_ier, data, 4'h3);
                t_done = $time;
            end
            begin
                @(posedge clk);
                #drive_delay;
                pause_req = 1'b1;
                n = 0;
                while (!pause_ack && n < wait_limit) begin
                    @(negedge clk);
                    n++;
                end
                if (!pause_ack) begin
                    raise_timeout("pause acknowledge");
                end
                repeat (5) @(posedge clk);
                #drive_delay;
                pause_req = 1'b0;
                t_rel = $time;
            end
        join
        checker_inst.check_true("write completed before pause release", t_done > t_rel);
        n = 0;
        while (pause_ack && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        checker_inst.check_true("pause_ack stuck high", !pause_ack);
        do_read(1'b0, reg_ier);
        checker_inst.end_test("pause handling");

        checker_inst.report_totals();
        if (checker_inst.error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gpio_subsys.f */
design/apb_pkg.sv
design/gpio_pkg.sv
design/apb_arbiter.sv
design/gpio_regs.sv
design/gpio_pad_ctrl.sv
design/gpio_subsys.sv
test/gpio_checker.sv
test/gpio_subsys_tb.sv

/* Bender.yml */
package:
  name: gpio_subsys

sources:
  - design/apb_pkg.sv
  - design/gpio_pkg.sv
  - design/apb_arbiter.sv
  - design/gpio_regs.sv
  - design/gpio_pad_ctrl.sv
  - design/gpio_subsys.sv
  - target: test
    files:
      - test/gpio_checker.sv
      - test/gpio_subsys_tb.sv
